// ==== sim.f ====
verilog/aluPkg.sv
verilog/aluCtrlIf.sv
verilog/aluRowDecoder.sv
verilog/aluControl.sv
verilog/aluDatapath.sv
verilog/aluFlags.sv
verilog/fx68kAlu.sv
sim/tbAlu.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tbAlu -f sim.f -o simAlu || exit 1
./obj_dir/simAlu > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && echo "Simulation FAILED" && exit 1
grep -q "All checks passed" sim.log && echo "Simulation PASSED" && exit 0
echo "Simulation ended without a result"
exit 1

// ==== sim/tbAlu.sv ====
// Vector-table testbench for the 68000 ALU top level; compile with sim.f, top module tbAlu
`timescale 1ns/1ps
`default_nettype none

module tbAlu;

	typedef struct {
		string name;
		logic [15:0] ird;
		logic [2:0] column;
		logic isByte;
		logic [1:0] dataCtrl; // 01 gives zero data for NOT
		logic addrSel;        // Address operand from alub
		logic finish;
		logic init;
		logic ftuLoad;        // Move to CCR
		logic [15:0] ftuVal;
		logic [15:0] data;    // iDataBus
		logic [15:0] addr;    // Address operand
		logic [15:0] expOut;
		logic [7:0] expCcr;
	} vecT;

	logic clk;
	logic rstN;
	logic enT3, enT4;
	logic [15:0] ird;
	logic [2:0] aluColumn;
	logic [1:0] aluDataCtrl;
	logic aluAddrCtrl;
	logic aluIsByte;
	logic ftu2Ccr, init, finish;
	logic [15:0] ftu, alub, iDataBus, iAddrBus;
	logic ze;
	logic [7:0] ccr;
	logic [15:0] aluOut;

	vecT vecs[32];
	int numVecs = 0;
	int cycleCount = 0;
	int cycleLimit = 1000; // Replaced once the table is built
	integer seed;

	fx68kAlu i_dut (
		.clk(clk), .rstN(rstN), .enT3(enT3), .enT4(enT4), .ird(ird),
		.aluColumn(aluColumn), .aluDataCtrl(aluDataCtrl), .aluAddrCtrl(aluAddrCtrl),
		.aluIsByte(aluIsByte), .ftu2Ccr(ftu2Ccr), .init(init), .finish(finish),
		.ftu(ftu), .alub(alub), .iDataBus(iDataBus), .iAddrBus(iAddrBus),
		.ze(ze), .ccr(ccr), .aluOut(aluOut)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run exceeded %0d cycles", cycleLimit);
			$display("Checks failed");
			$fatal(1, "Simulation timed out");
		end
	end

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
			$display("Checks failed");
			$fatal(1, "Mismatch in %s", testName);
		end
	endtask

	// mode is {isByte, finish, init}
	task automatic addVec(input string name, input logic [15:0] irdVal, input logic [2:0] col,
		input logic [2:0] mode, input logic [15:0] data, input logic [15:0] addr,
		input logic [15:0] expOut, input logic [7:0] expCcr);
		vecs[numVecs] = '{name, irdVal, col, mode[2], 2'b00, 1'b0, mode[1], mode[0], 1'b0,
			16'h0000, data, addr, expOut, expCcr};
		numVecs++;
	endtask

	// Column 0, so aluOut holds
	task automatic addFtuVec(input string name, input logic [15:0] ftuVal,
		input logic [15:0] expOut, input logic [7:0] expCcr);
		vecs[numVecs] = '{name, 16'h0000, 3'd0, 1'b0, 2'b00, 1'b0, 1'b0, 1'b0, 1'b1, ftuVal,
			16'h0000, 16'h0000, expOut, expCcr};
		numVecs++;
	endtask

	// EOR.W D1,D0 with random operands, X from the previous row
	task automatic addEorVec(input string name, input logic xKept);
		logic [31:0] rnd;
		logic [15:0] d, a, r;
		rnd = $random(seed);
		d = rnd[15:0];
		rnd = $random(seed);
		a = rnd[15:0];
		r = d ^ a;
		addVec(name, 16'hB340, 3'd2, 3'b001, d, a, r,
			{3'b000, xKept, r[15], (r == 16'h0000), 2'b00});
	endtask

	task automatic buildTable();
		addFtuVec("CCR load masks ftu", 16'hFFE4, 16'h0000, 8'h04);
		addVec("ADD.W carry to zero", 16'hD240, 3'd2, 3'b010, 16'hFFFF, 16'h0001, 16'h0000, 8'h15);
		addVec("ADD.W overflow", 16'hD240, 3'd2, 3'b010, 16'h7FFF, 16'h0001, 16'h8000, 8'h0A);
		addVec("SUB.W borrow", 16'h9240, 3'd2, 3'b010, 16'h0003, 16'h0005, 16'hFFFE, 8'h19);
		addVec("SUB.W overflow", 16'h9240, 3'd2, 3'b010, 16'h8000, 16'h0001, 16'h7FFF, 8'h02);
		addVec("ADD.B overflow", 16'hD000, 3'd2, 3'b101, 16'hAB50, 16'hCD30, 16'hFF80, 8'h0A);
		addVec("ADD.B carry zero", 16'hD000, 3'd2, 3'b101, 16'h1270, 16'h3490, 16'h0000, 8'h15);
		addVec("AND.W", 16'hC240, 3'd2, 3'b001, 16'hF0F0, 16'hFF00, 16'hF000, 8'h18);
		vecs[numVecs-1].addrSel = 1'b1; // Operand from alub, iAddrBus holds filler
		addVec("OR.W zero", 16'h8240, 3'd2, 3'b001, 16'h0000, 16'h0000, 16'h0000, 8'h14);
		addEorVec("EOR.W random 1", 1'b1);
		addEorVec("EOR.W random 2", 1'b1);
		addVec("NOT.W", 16'h4640, 3'd2, 3'b001, 16'h5555, 16'h00FF, 16'hFF00, 8'h18);
		vecs[numVecs-1].dataCtrl = 2'b01; // Zero minus operand minus one
		addVec("ASL.W sign change", 16'hE340, 3'd4, 3'b001, 16'h0000, 16'h4001, 16'h8002, 8'h0A);
		addVec("LSR.W", 16'hE248, 3'd4, 3'b001, 16'h0000, 16'h0003, 16'h0001, 8'h11);
		addVec("ROL.W keeps X", 16'hE358, 3'd4, 3'b001, 16'h0000, 16'h4000, 16'h8000, 8'h18);
		addVec("ROXR.W X in", 16'hE250, 3'd4, 3'b001, 16'h0000, 16'h0002, 16'h8001, 8'h08);
		addVec("ADDX.W Z clear", 16'hD340, 3'd2, 3'b001, 16'h0000, 16'h0000, 16'h0000, 8'h00);
		addFtuVec("CCR load Z", 16'h0004, 16'h0000, 8'h04);
		addVec("ADDX.W Z kept", 16'hD340, 3'd2, 3'b001, 16'hFFFF, 16'h0001, 16'h0000, 8'h15);
		addVec("ADDA.W no flags", 16'hD2C0, 3'd2, 3'b010, 16'h1234, 16'h0001, 16'h1235, 8'h15);
	endtask

	// enT3 decode, enT4 select, enT3 execute, then sample
	task automatic applyVec(input int idx);
		vecT v;
		v = vecs[idx];
		@(negedge clk);
		ird = v.ird;
		aluIsByte = v.isByte;
		aluDataCtrl = v.dataCtrl;
		iDataBus = v.data;
		aluAddrCtrl = v.addrSel;
		alub = v.addrSel ? v.addr : 16'hA5A5; // Filler on the unselected bus
		iAddrBus = v.addrSel ? 16'hA5A5 : v.addr;
		ftu = v.ftuVal;
		enT3 = 1'b1;
		@(negedge clk);
		enT3 = 1'b0;
		enT4 = 1'b1;
		aluColumn = v.column;
		finish = v.finish; // Column 1 mask depends on it
		@(negedge clk);
		enT4 = 1'b0;
		enT3 = 1'b1;
		init = v.init;
		ftu2Ccr = v.ftuLoad;
		@(negedge clk);
		enT3 = 1'b0;
		aluColumn = 3'd0;
		finish = 1'b0;
		init = 1'b0;
		ftu2Ccr = 1'b0;
		checkValue({v.name, " aluOut"}, 32'(v.expOut), 32'(aluOut));
		checkValue({v.name, " ccr"}, 32'(v.expCcr), 32'(ccr));
		// Core Z follows the executed result, sign-extended bytes included
		if (v.column != 3'd0)
			checkValue({v.name, " ze"}, 32'(v.expOut != 16'h0000), 32'(ze));
	endtask

	initial begin
		rstN = 1'b0;
		enT3 = 1'b0;
		enT4 = 1'b0;
		ird = 16'h0000;
		aluColumn = 3'd0;
		aluDataCtrl = 2'b00;
		aluAddrCtrl = 1'b0; // Address operand from iAddrBus
		aluIsByte = 1'b0;
		ftu2Ccr = 1'b0;
		init = 1'b0;
		finish = 1'b0;
		ftu = 16'h0000;
		alub = 16'hA5A5;    // Filler while iAddrBus is selected
		iDataBus = 16'h0000;
		iAddrBus = 16'h0000;
		seed = 32'hcf31f3ce;
		buildTable();
		cycleLimit = numVecs * 8 + 20;
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		checkValue("reset ccr", 32'h0, 32'(ccr));
		checkValue("reset ze", 32'h1, 32'(ze));
		checkValue("reset aluOut", 32'h0, 32'(aluOut));
		for (int i = 0; i < numVecs; i++)
			applyVec(i);
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/fx68kAlu.sv ====
// 68000 ALU top level with plain ports; connects control, datapath and flag units
`timescale 1ns/1ps
`default_nettype none

module fx68kAlu (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic enT4,
	input logic [15:0] ird,
	input logic [2:0] aluColumn,
	input logic [1:0] aluDataCtrl,
	input logic aluAddrCtrl,
	input logic aluIsByte,
	input logic ftu2Ccr,
	input logic init,
	input logic finish,
	input logic [15:0] ftu,
	input logic [aluPkg::dataWidth-1:0] alub,
	input logic [aluPkg::dataWidth-1:0] iDataBus,
	input logic [aluPkg::dataWidth-1:0] iAddrBus,
	output logic ze,
	output logic [7:0] ccr,
	output logic [aluPkg::dataWidth-1:0] aluOut
);
	import aluPkg::*;

	aluRowT row;  // Registered row for the column-1 ROX rule
	logic xFlag;  // Status X into carry-in
	logic coreC;

	aluCtrlIf ctrlBus ();
	aluResIf resBus ();

	aluControl i_control (
		.clk(clk),
		.rstN(rstN),
		.enT3(enT3),
		.enT4(enT4),
		.ird(ird),
		.aluIsByte(aluIsByte),
		.aluColumn(aluColumn),
		.finish(finish),
		.row(row),
		.ctrl(ctrlBus.ctrl)
	);

	aluDatapath i_datapath (
		.clk(clk),
		.rstN(rstN),
		.enT3(enT3),
		.aluDataCtrl(aluDataCtrl),
		.aluAddrCtrl(aluAddrCtrl),
		.alub(alub),
		.iAddrBus(iAddrBus),
		.iDataBus(iDataBus),
		.xFlag(xFlag),
		.coreC(coreC),
		.ctrl(ctrlBus.reader),
		.res(resBus.exec),
		.aluOut(aluOut)
	);

	aluFlags i_flags (
		.clk(clk),
		.rstN(rstN),
		.enT3(enT3),
		.finish(finish),
		.init(init),
		.ftu2Ccr(ftu2Ccr),
		.ftu(ftu),
		.row(row),
		.ctrl(ctrlBus.reader),
		.res(resBus.flags),
		.xFlag(xFlag),
		.coreC(coreC),
		.ccr(ccr),
		.ze(ze)
	);

endmodule

`default_nettype wire

// ==== verilog/aluFlags.sv ====
// Condition code unit: raw flags per operation, masking, core flags and status flags
`timescale 1ns/1ps
`default_nettype none

module aluFlags (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic finish,
	input logic init,
	input logic ftu2Ccr,
	input logic [15:0] ftu,
	input aluPkg::aluRowT row,
	aluCtrlIf.reader ctrl,
	aluResIf.flags res,
	output logic xFlag,
	output logic coreC,
	output logic [7:0] ccr,
	output logic ze
);
	import aluPkg::*;

	ccrT pswCcr;  // Status register flags
	ccrT ccrCore; // Internal flags, updated every executing column
	ccrT ccrTemp;
	ccrT ccrMasked;
	logic roxCol1;

	// ROX with zero count only reaches column 1, C takes X there
	assign roxCol1 = (ctrl.column == 3'd1) && ((row & (rowRoxr | rowNot)) != '0);

	always_comb begin
		ccrTemp = '0;
		ccrTemp[flagX] = pswCcr[flagX];
		ccrTemp[flagZ] = ctrl.isByte ? ~(|res.result[7:0]) : ~(|res.result);
		ccrTemp[flagN] = ctrl.isByte ? res.result[7] : res.result[15];
		case (ctrl.oper)
			aluAnd: ccrTemp[flagC] = roxCol1 ? pswCcr[flagX] : 1'b0;
			aluSlaa: ccrTemp[flagC] = res.shiftMsb;
			aluLsl, aluRoxl: begin
				ccrTemp[flagC] = res.shiftMsb;
				ccrTemp[flagX] = res.shiftMsb;
			end
			aluLsr, aluRoxr, aluAsr: begin
				ccrTemp[flagC] = res.shiftLsb;
				ccrTemp[flagX] = res.shiftLsb;
			end
			aluAsl: begin
				ccrTemp[flagC] = res.shiftMsb;
				ccrTemp[flagX] = res.shiftMsb;
				ccrTemp[flagV] = pswCcr[flagV] | res.aslMsbChange; // Any sign change over the loop
			end
			aluRol: ccrTemp[flagC] = res.shiftMsb; // X kept
			aluRor: ccrTemp[flagC] = res.shiftLsb;
			aluAdd, aluAddc, aluAddx, aluSub, aluSubc, aluSubx: begin
				ccrTemp[flagC] = res.addCout;
				ccrTemp[flagX] = res.addCout;
				ccrTemp[flagV] = res.addOv;
			end
			default: ccrTemp[flagC] = 1'b0; // OR, EOR, SUB0, EXT clear C and V
		endcase
	end

	// Unmasked flags keep the status value
	always_comb begin
		ccrMasked = (ccrTemp & ctrl.ccrMask) | (pswCcr & ~ctrl.ccrMask);
		if (finish || ctrl.isArX)
			ccrMasked[flagZ] = ccrTemp[flagZ] & pswCcr[flagZ]; // Z only clears
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ccrCore <= '0;
			pswCcr <= '0;
		end else if (enT3) begin
			if (ctrl.column != 3'd0)
				ccrCore <= ccrTemp;
			if (ftu2Ccr)
				pswCcr <= ftu[4:0]; // Move to CCR
			else if (!ctrl.noCcrEn && (finish || init))
				pswCcr <= ccrMasked;
		end
	end

	assign xFlag = pswCcr[flagX];
	assign coreC = ccrCore[flagC];
	assign ze = ~ccrCore[flagZ];
	assign ccr = {3'b000, pswCcr};

	// X-extended forms never set a clear Z
	zStickyArX: assert property (@(posedge clk) disable iff (!rstN)
		(enT3 && ctrl.isArX && !ftu2Ccr && !pswCcr[flagZ]) |=> !pswCcr[flagZ]);

endmodule

`default_nettype wire

// ==== verilog/aluDatapath.sv ====
// ALU datapath: operand muxes, adder, logic, EXT, one-bit shifter and the result latch
`timescale 1ns/1ps
`default_nettype none

module aluDatapath (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic [1:0] aluDataCtrl,
	input logic aluAddrCtrl,
	input logic [aluPkg::dataWidth-1:0] alub,
	input logic [aluPkg::dataWidth-1:0] iAddrBus,
	input logic [aluPkg::dataWidth-1:0] iDataBus,
	input logic xFlag,
	input logic coreC,
	aluCtrlIf.reader ctrl,
	aluResIf.exec res,
	output logic [aluPkg::dataWidth-1:0] aluOut
);
	import aluPkg::*;

	logic [dataWidth-1:0] aOperand; // Destination side
	logic [dataWidth-1:0] dOperand; // Source side
	logic [dataWidth-1:0] addResult;
	logic [dataWidth-1:0] shiftResult;
	logic [dataWidth-1:0] result;
	logic [dataWidth:0] wordSum;
	logic [8:0] byteSum;
	logic isAdd;
	logic addCin;
	logic shiftCin;
	logic shiftRight;
	logic rMsb, dMsb, sMsb;

	assign aOperand = aluAddrCtrl ? alub : iAddrBus;

	always_comb begin
		case (aluDataCtrl)
			2'b00: dOperand = iDataBus;
			2'b01: dOperand = '0;
			2'b11: dOperand = '1;
			default: dOperand = '0; // BCD correction path not present
		endcase
	end

	assign isAdd = (ctrl.oper == aluAdd) || (ctrl.oper == aluAddc) || (ctrl.oper == aluAddx);

	always_comb begin
		case (ctrl.oper)
			aluSub0: addCin = 1'b1;
			aluAddc, aluSubc: addCin = coreC;
			aluAddx, aluSubx: addCin = xFlag; // Extend flag from status
			default: addCin = 1'b0;
		endcase
	end

	// Data plus or minus address
	assign wordSum = isAdd ? {1'b0, dOperand} + {1'b0, aOperand} + 17'(addCin)
		: {1'b0, dOperand} - {1'b0, aOperand} - 17'(addCin);
	assign byteSum = isAdd ? {1'b0, dOperand[7:0]} + {1'b0, aOperand[7:0]} + 9'(addCin)
		: {1'b0, dOperand[7:0]} - {1'b0, aOperand[7:0]} - 9'(addCin);
	assign addResult = ctrl.isByte ? {{8{byteSum[7]}}, byteSum[7:0]} : wordSum[15:0];

	// Signed overflow from operand and result signs
	assign rMsb = ctrl.isByte ? byteSum[7] : wordSum[15];
	assign dMsb = ctrl.isByte ? dOperand[7] : dOperand[15];
	assign sMsb = isAdd ? (ctrl.isByte ? aOperand[7] : aOperand[15])
		: ~(ctrl.isByte ? aOperand[7] : aOperand[15]);

	assign res.addCout = ctrl.isByte ? byteSum[8] : wordSum[16];
	assign res.addOv = (sMsb & dMsb & ~rMsb) | (~sMsb & ~dMsb & rMsb);

	assign res.shiftMsb = ctrl.isByte ? aOperand[7] : aOperand[15];
	assign res.shiftLsb = aOperand[0];
	assign res.aslMsbChange = res.shiftMsb ^ (ctrl.isByte ? aOperand[6] : aOperand[14]);

	// Direction and fill bit
	always_comb begin
		shiftRight = 1'b0;
		shiftCin = 1'b0; // LSL, LSR, ASL
		case (ctrl.oper)
			aluAsr: begin
				shiftRight = 1'b1;
				shiftCin = res.shiftMsb; // Sign stays
			end
			aluLsr: shiftRight = 1'b1;
			aluRol: shiftCin = res.shiftMsb;
			aluRor: begin
				shiftRight = 1'b1;
				shiftCin = aOperand[0];
			end
			aluRoxl: shiftCin = xFlag;
			aluRoxr: begin
				shiftRight = 1'b1;
				shiftCin = xFlag;
			end
			aluSlaa: shiftCin = ctrl.column[1]; // Col 4 gives 0, col 6 gives 1
			default: shiftCin = 1'b0;
		endcase
	end

	// Byte right shift fills bit 7, upper byte left alone
	assign shiftResult = !shiftRight ? {aOperand[14:0], shiftCin}
		: (ctrl.isByte ? {aOperand[15:8], shiftCin, aOperand[7:1]} : {shiftCin, aOperand[15:1]});

	always_comb begin
		case (ctrl.oper)
			aluAnd: result = aOperand & dOperand;
			aluOr: result = aOperand | dOperand;
			aluEor: result = aOperand ^ dOperand;
			aluExt: result = {{8{aOperand[7]}}, aOperand[7:0]};
			aluAsl, aluAsr, aluLsl, aluLsr, aluRol, aluRor, aluRoxl, aluRoxr, aluSlaa:
				result = shiftResult;
			default: result = addResult; // Add and subtract family
		endcase
	end

	assign res.result = result;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			aluOut <= '0;
		else if (enT3 && ctrl.column != 3'd0)
			aluOut <= result;
	end

	noCorfSelect: assert property (@(posedge clk) disable iff (!rstN)
		(enT3 && ctrl.column != 3'd0) |-> aluDataCtrl != 2'b10);

endmodule

`default_nettype wire

// ==== verilog/aluControl.sv ====
// ALU control: latches the decoded row on enT3, then operation and flag mask on enT4
`timescale 1ns/1ps
`default_nettype none

module aluControl (
	input logic clk,
	input logic rstN,
	input logic enT3,
	input logic enT4,
	input logic [15:0] ird,
	input logic aluIsByte,
	input logic [2:0] aluColumn,
	input logic finish,
	output aluPkg::aluRowT row,
	aluCtrlIf.ctrl ctrl
);
	import aluPkg::*;

	aluRowT decRow;
	logic decIsArX;
	logic decNoCcrEn;
	aluOpT nextOper;
	ccrT nextMask;
	ccrT col1Mask;

	aluRowDecoder i_rowDecoder (
		.ird(ird),
		.row(decRow),
		.isArX(decIsArX),
		.noCcrEn(decNoCcrEn)
	);

	// Column 1 is AND for every row
	assign col1Mask = finish ? maskNzOnly : (((row & (rowEor | rowOr)) != '0) ? maskZOnly : maskNzvc);

	// Operation from row and column
	always_comb begin
		nextOper = aluAnd;
		case (aluColumn)
			3'd1: nextOper = aluAnd;
			3'd5: nextOper = aluExt;
			3'd6: nextOper = aluSlaa; // Fill with 1
			default: begin
				case (1'b1)
					row[2]: nextOper = (aluColumn == 3'd2) ? aluAdd
						: ((aluColumn == 3'd3) ? aluAddc : aluAsr);
					row[3]: nextOper = (aluColumn == 3'd2) ? aluAddx
						: ((aluColumn == 3'd3) ? aluAdd : aluAsl);
					row[4]: nextOper = (aluColumn == 3'd4) ? aluLsl : aluAnd;
					row[5], row[6]: nextOper = (aluColumn == 3'd2) ? aluSub
						: ((aluColumn == 3'd3) ? aluSubc : aluLsr);
					row[8]: nextOper = (aluColumn == 3'd2) ? aluExt
						: ((aluColumn == 3'd3) ? aluAnd : aluRoxr);
					row[9]: nextOper = (aluColumn == 3'd2) ? aluSubx
						: ((aluColumn == 3'd3) ? aluSubc : aluRol);
					row[10]: nextOper = (aluColumn == 3'd2) ? aluSubx
						: ((aluColumn == 3'd3) ? aluSubc : aluRor);
					row[11]: nextOper = (aluColumn == 3'd4) ? aluRoxl : aluSub0;
					row[12]: nextOper = aluAddx;
					row[13]: nextOper = aluEor;
					row[14]: nextOper = (aluColumn == 3'd4) ? aluEor : aluOr;
					row[15]: nextOper = (aluColumn == 3'd3) ? aluAdd : aluOr; // ADD for DBcc
					default: nextOper = aluAnd;
				endcase
			end
		endcase
	end

	// Flags the operation may touch
	always_comb begin
		nextMask = maskNone;
		case (aluColumn)
			3'd1: nextMask = col1Mask;
			3'd2, 3'd3: begin
				case (1'b1)
					row[2], row[3], row[5], row[9], row[10], row[12]: nextMask = maskAll;
					row[4], row[6], row[8], row[11], row[13], row[14]: nextMask = maskNzvc;
					default: nextMask = maskNone; // TST row and row 0
				endcase
			end
			3'd4: begin
				case (1'b1)
					row[2], row[3], row[4], row[5], row[11]: nextMask = maskAll; // Shifts, ROXL
					row[8]: nextMask = maskAll;                   // ROXR sets X
					row[9], row[10]: nextMask = maskNzvc;         // ROL, ROR keep X
					default: nextMask = maskNone;
				endcase
			end
			default: nextMask = maskNone; // EXT, SLAA
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			row <= '0;
			ctrl.isByte <= 1'b0;
			ctrl.isArX <= 1'b0;
			ctrl.noCcrEn <= 1'b0;
			ctrl.oper <= aluAnd;
			ctrl.ccrMask <= maskNone;
		end else begin
			if (enT3) begin
				row <= decRow;
				ctrl.isByte <= aluIsByte;
				ctrl.isArX <= decIsArX;
				ctrl.noCcrEn <= decNoCcrEn;
			end
			if (enT4) begin
				ctrl.oper <= nextOper;
				ctrl.ccrMask <= nextMask;
			end
		end
	end

	assign ctrl.column = aluColumn; // Column is live on the executing enT3

	// Every live row/column pair must hit the table
	opMaskKnown: assert property (@(posedge clk) disable iff (!rstN)
		(enT4 && aluColumn != 3'd0 && row != '0) |-> !$isunknown({nextOper, nextMask}));

endmodule

`default_nettype wire

// ==== verilog/aluRowDecoder.sv ====
// Instruction register to one-hot ALU row decoder, with the flag qualifiers; used by aluControl
`timescale 1ns/1ps
`default_nettype none

module aluRowDecoder (
	input logic [15:0] ird,
	output aluPkg::aluRowT row,
	output logic isArX,
	output logic noCcrEn
);
	import aluPkg::*;

	logic eaRdir;          // Dn or An direct
	logic eaAdir;          // An direct
	logic size11;
	logic [1:0] shiftType; // AS, LS, ROX, RO

	assign eaRdir = (ird[5:4] == 2'b00);
	assign eaAdir = (ird[5:3] == 3'b001);
	assign size11 = ird[7] & ird[6];
	assign shiftType = size11 ? ird[10:9] : ird[4:3]; // Memory form vs register form

	always_comb begin
		row = '0;
		case (ird[15:12])
			4'h0: begin
				if (ird[8])
					row = ird[7] ? rowOr : rowEor; // Dynamic bit ops
				else begin
					case (ird[11:9])
						3'b000: row = rowOr;      // ORI
						3'b001: row = rowAnd;     // ANDI
						3'b010: row = rowSub;     // SUBI
						3'b011: row = rowAddMove; // ADDI
						3'b100: row = ird[7] ? rowOr : rowEor; // Static bit ops
						3'b101: row = rowEor;     // EORI
						3'b110: row = rowCmp;     // CMPI
						default: row = '0;
					endcase
				end
			end
			4'h1, 4'h2, 4'h3, 4'h7: row = rowAddMove; // MOVE, MOVEQ
			4'h4: begin
				if (ird[8])
					row = rowCmp; // CHK
				else begin
					case (ird[11:9])
						3'b000: row = rowSubx; // NEGX
						3'b001: row = rowAnd;  // CLR
						3'b010: row = rowSub;  // NEG
						3'b011: row = rowNot;
						3'b100: row = ird[7] ? rowRoxr : (ird[6] ? rowRol : '0); // EXT, SWAP; NBCD out
						3'b101: row = rowTst;
						default: row = '0;
					endcase
				end
			end
			4'h5: begin
				if (size11)
					row = rowTst; // Scc, DBcc
				else
					row = ird[8] ? rowSub : rowAddMove; // SUBQ, ADDQ
			end
			4'h8: row = (size11 | (ird[8] & eaRdir)) ? '0 : rowOr;  // DIV and SBCD map to 0
			4'h9: row = (ird[8] & ~size11 & eaRdir) ? rowSubx : rowSub;
			4'hb: row = (ird[8] & ~size11 & ~eaAdir) ? rowEor : rowCmp;
			4'hc: row = (size11 | (ird[8] & eaRdir)) ? '0 : rowAnd; // MUL and ABCD map to 0
			4'hd: row = (ird[8] & ~size11 & eaRdir) ? rowAddx : rowAddMove;
			4'he: begin
				case ({shiftType, ird[8]})
					3'd0: row = rowAddMove; // ASR
					3'd1: row = rowAsl;
					3'd2: row = rowSub;     // LSR
					3'd3: row = rowAnd;     // LSL
					3'd4: row = rowRoxr;
					3'd5: row = rowNot;     // ROXL
					3'd6: row = rowSubx;    // ROR
					default: row = rowRol;
				endcase
			end
			default: row = '0; // Bcc, line A, line F
		endcase
	end

	// NEGX, SUBX, ADDX only
	assign isArX = (ird[15:12] == 4'h4 || ird[15:12] == 4'h9 || ird[15:12] == 4'hd)
		&& ((row & (rowSubx | rowAddx)) != '0);

	assign noCcrEn = (ird[15] & ~ird[13] & ird[12] & size11) // ADDA, SUBA
		| ((ird[15:12] == 4'h5) & eaAdir)                     // ADDQ, SUBQ to An
		| (~ird[15] & ~ird[14] & ird[13] & (ird[8:6] == 3'b001)); // MOVEA

endmodule

`default_nettype wire

// ==== verilog/aluCtrlIf.sv ====
// Interfaces between ALU units: registered control word, and combinational execution results
`timescale 1ns/1ps
`default_nettype none

interface aluCtrlIf;
	import aluPkg::*;

	aluOpT oper;        // Registered on enT4
	ccrT ccrMask;
	logic isByte;       // Registered on enT3
	logic isArX;        // Z sticky, X-extended forms
	logic noCcrEn;      // Address destination, flags untouched
	logic [2:0] column; // Current microcode column

	modport ctrl (output oper, ccrMask, isByte, isArX, noCcrEn, column);
	modport reader (input oper, ccrMask, isByte, isArX, noCcrEn, column);
endinterface

interface aluResIf;
	import aluPkg::*;

	logic [dataWidth-1:0] result; // Selected operator output
	logic addCout;                // Adder carry or borrow, size adjusted
	logic addOv;
	logic shiftMsb;               // Bit leaving on a left shift
	logic shiftLsb;               // Bit leaving on a right shift
	logic aslMsbChange;           // Sign changes on ASL

	modport exec (output result, addCout, addOv, shiftMsb, shiftLsb, aslMsbChange);
	modport flags (input result, addCout, addOv, shiftMsb, shiftLsb, aslMsbChange);
endinterface

`default_nettype wire

// ==== verilog/aluPkg.sv ====
// Shared ALU operation codes, row codes, flag positions and flag masks; imported by the ALU units
`default_nettype none

package aluPkg;

	localparam int dataWidth = 16; // Data bus, operands and result

	// Operations picked from the row/column table
	typedef enum logic [4:0] {
		aluAnd, aluOr, aluEor, aluExt,
		aluAdd, aluAddc, aluAddx,
		aluSub, aluSubc, aluSubx,
		aluSub0, // NOT as 0 - op - 1
		aluAsl, aluAsr, aluLsl, aluLsr,
		aluRol, aluRor, aluRoxl, aluRoxr,
		aluSlaa // Shift left with column-dependent fill
	} aluOpT;

	typedef logic [15:0] aluRowT; // One-hot, row 0 means no ALU work
	typedef logic [4:0] ccrT;     // X N Z V C

	// Flag bit positions
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	// Rows still in use
	localparam aluRowT rowAddMove = 16'h0004; // ADD, MOVE, ADDQ, ASR
	localparam aluRowT rowAsl     = 16'h0008;
	localparam aluRowT rowAnd     = 16'h0010; // AND, CLR, LSL
	localparam aluRowT rowSub     = 16'h0020; // SUB, NEG, LSR
	localparam aluRowT rowCmp     = 16'h0040; // CMP, CHK
	localparam aluRowT rowRoxr    = 16'h0100; // Also EXT
	localparam aluRowT rowRol     = 16'h0200; // Also SWAP
	localparam aluRowT rowSubx    = 16'h0400; // SUBX, NEGX, ROR
	localparam aluRowT rowNot     = 16'h0800; // NOT, ROXL
	localparam aluRowT rowAddx    = 16'h1000;
	localparam aluRowT rowEor     = 16'h2000; // EOR, bit ops on Dn
	localparam aluRowT rowOr      = 16'h4000;
	localparam aluRowT rowTst     = 16'h8000; // TST, TAS, Scc

	// Flags an operation is allowed to change
	localparam ccrT maskNzOnly = 5'b01100;
	localparam ccrT maskZOnly  = 5'b00100;
	localparam ccrT maskNzvc   = 5'b01111; // V and C cleared by the operator
	localparam ccrT maskAll    = 5'b11111;
	localparam ccrT maskNone   = 5'b00000;

endpackage

`default_nettype wire
